// ==== Makefile ====
# Verilator run of the batch scheduler testbench
VERILATOR ?= verilator
TOP       ?= tb_batch_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean

// ==== batch_tracker/batch_tracker.sv ====
/* Batch life tracker. Three step FSMs (command, sample, result) linked by credit
   and pending counters, with a shift line standing in for the key load. */
`timescale 1ns/10ps
`default_nettype none

module batch_tracker (
  input  wire                   clk,
  input  wire                   s_rst_n,

  input  wire batch_pkg::batch_cmd_t q_cmd,
  input  wire                   q_vld,
  output logic                  q_pop,

  output batch_pkg::batch_cmd_t core_cmd,
  output logic                  core_cmd_vld,
  output logic                  send_data,
  input  wire                   in_last,
  input  wire                   out_last,

  output logic                  all_idle
);

  typedef enum logic {
    cmd_st_wait,
    cmd_st_send
  } cmd_st_e;

  typedef enum logic {
    data_st_wait,
    data_st_send
  } data_st_e;

  typedef enum logic {
    rsp_st_wait,
    rsp_st_receive
  } rsp_st_e;

  cmd_st_e                       cmd_st;
  cmd_st_e                       cmd_st_nxt;
  data_st_e                      data_st;
  data_st_e                      data_st_nxt;
  rsp_st_e                       rsp_st;
  rsp_st_e                       rsp_st_nxt;

  // Free slots, batches waiting for samples, batches waiting for results
  batch_pkg::batch_cnt_t         credit_cnt;
  batch_pkg::batch_cnt_t         data_cnt;
  batch_pkg::batch_cnt_t         rsp_cnt;

  logic [batch_pkg::batch_dly-1:0] issue_sr;
  logic                          issue_dly;

  // ------------------------------
  // Step state machines
  // ------------------------------
  always_comb begin
    cmd_st_nxt = cmd_st;
    case (cmd_st)
      cmd_st_wait: begin
        if (q_vld && credit_cnt != '0) begin
          cmd_st_nxt = cmd_st_send;
        end
      end
      // Single cycle, the pop happens here
      cmd_st_send: cmd_st_nxt = cmd_st_wait;
      default:     cmd_st_nxt = cmd_st_wait;
    endcase
  end

  always_comb begin
    data_st_nxt = data_st;
    case (data_st)
      data_st_wait: begin
        if (data_cnt != '0) begin
          data_st_nxt = data_st_send;
        end
      end
      data_st_send: begin
        if (in_last) begin
          data_st_nxt = data_st_wait;
        end
      end
      default: data_st_nxt = data_st_wait;
    endcase
  end

  always_comb begin
    rsp_st_nxt = rsp_st;
    case (rsp_st)
      rsp_st_wait: begin
        if (rsp_cnt != '0) begin
          rsp_st_nxt = rsp_st_receive;
        end
      end
      rsp_st_receive: begin
        if (out_last) begin
          rsp_st_nxt = rsp_st_wait;
        end
      end
      default: rsp_st_nxt = rsp_st_wait;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cmd_st  <= cmd_st_wait;
      data_st <= data_st_wait;
      rsp_st  <= rsp_st_wait;
    end else begin
      cmd_st  <= cmd_st_nxt;
      data_st <= data_st_nxt;
      rsp_st  <= rsp_st_nxt;
    end
  end

  assign q_pop        = (cmd_st == cmd_st_send);
  assign core_cmd     = q_cmd;
  assign core_cmd_vld = q_pop;
  assign send_data    = (data_st == data_st_send);

  assign all_idle = (cmd_st == cmd_st_wait) & (data_st == data_st_wait) &
                    (rsp_st == rsp_st_wait) &
                    (credit_cnt == batch_pkg::batch_cnt_t'(batch_pkg::batch_nb));

  // ------------------------------
  // Key load delay line
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      issue_sr <= '0;
    end else begin
      issue_sr <= {issue_sr[batch_pkg::batch_dly-2:0], q_pop};
    end
  end

  assign issue_dly = issue_sr[batch_pkg::batch_dly-1];

  // ------------------------------
  // Hand-over counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      credit_cnt <= batch_pkg::batch_cnt_t'(batch_pkg::batch_nb);
      data_cnt   <= '0;
      rsp_cnt    <= '0;
    end else begin
      case ({q_pop, out_last})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      case ({issue_dly, in_last})
        2'b10:   data_cnt <= data_cnt + 1'b1;
        2'b01:   data_cnt <= data_cnt - 1'b1;
        default: data_cnt <= data_cnt;
      endcase
      case ({in_last, out_last})
        2'b10:   rsp_cnt <= rsp_cnt + 1'b1;
        2'b01:   rsp_cnt <= rsp_cnt - 1'b1;
        default: rsp_cnt <= rsp_cnt;
      endcase
    end
  end

  // Core never reports more finished batches than were issued
  assert property (@(posedge clk) disable iff (!s_rst_n)
    credit_cnt <= batch_pkg::batch_cnt_t'(batch_pkg::batch_nb))
    else $error("batch_tracker: credit count above batch_nb");

  assert property (@(posedge clk) disable iff (!s_rst_n)
    q_pop |-> q_vld)
    else $error("batch_tracker: pop on empty command queue");

endmodule

`default_nettype wire

// ==== common/batch_pkg.sv ====
/* Shared widths, limits and vector types for the batch scheduling subsystem.
   Every module refers to these by scoped name. */
`default_nettype none

package batch_pkg;

  // ------------------------------
  // Limits and delays
  // ------------------------------
  // Batches alive at once
  localparam int batch_nb   = 2;
  localparam int max_pbs_nb = 8;
  // Key load stand-in between command issue and sample step
  localparam int batch_dly  = 16;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int sample_w  = 16;
  localparam int loop_w    = 8;
  localparam int pbs_w     = 4;
  localparam int cmd_w     = loop_w + pbs_w;
  localparam int res_depth = batch_nb * max_pbs_nb;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [sample_w-1:0] sample_t;
  typedef logic [loop_w-1:0]   br_loop_t;
  // Legal sample counts are 1 to max_pbs_nb
  typedef logic [pbs_w-1:0]    pbs_nb_t;
  // Loop count in the upper bits, sample count in the lower bits
  typedef logic [cmd_w-1:0]    batch_cmd_t;

  // Index into a batch_nb deep store, and a count of 0 to batch_nb batches
  typedef logic [$clog2(batch_nb)-1:0]   batch_ptr_t;
  typedef logic [$clog2(batch_nb+1)-1:0] batch_cnt_t;

endpackage

`default_nettype wire

// ==== dv/tb_batch_top.sv ====
/* Directed testbench for batch_top. Pushes commands through the host handshake,
   feeds samples, and checks results, last flags, idle flag and in-flight limit. */
`timescale 1ns/10ps
`default_nettype none

module tb_batch_top;

  // Up to 60 batches with each worth twice the key load plus input and output beats
  localparam int timeout_cycles =
    2 * 60 * (batch_pkg::batch_dly + 2 * batch_pkg::max_pbs_nb) + 160;

  logic                  clk;
  logic                  s_rst_n;
  batch_pkg::batch_cmd_t host_cmd;
  logic                  host_req;
  logic                  host_ack;
  batch_pkg::sample_t    sample_in;
  logic                  sample_vld;
  logic                  sample_rdy;
  batch_pkg::sample_t    result;
  logic                  result_vld;
  logic                  result_last;
  logic                  all_idle;

  // Samples still to present, and the results they must produce
  batch_pkg::sample_t    feed_q[$];
  bit                    feed_first_q[$];
  batch_pkg::sample_t    exp_q[$];
  bit                    exp_last_q[$];
  bit                    feed_hold = 1'b0;

  int unsigned           lcg_state = 32'hfaa9e6be;
  int                    cycle_cnt = 0;
  int                    err_cnt = 0;
  int                    check_cnt = 0;
  int                    beat_cnt = 0;
  int                    in_flight = 0;
  int                    max_in_flight = 0;
  bit                    first_acc;
  bit                    exp_last;
  batch_pkg::sample_t    exp_res;

  tb_clk_gen u_clk_gen (
    .clk     (clk),
    .s_rst_n (s_rst_n)
  );

  batch_top UUT (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .host_cmd    (host_cmd),
    .host_req    (host_req),
    .host_ack    (host_ack),
    .sample_in   (sample_in),
    .sample_vld  (sample_vld),
    .sample_rdy  (sample_rdy),
    .result      (result),
    .result_vld  (result_vld),
    .result_last (result_last),
    .all_idle    (all_idle)
  );

  // ------------------------------
  // Random numbers and reporting
  // ------------------------------
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic batch_pkg::br_loop_t rand_loop();
    return batch_pkg::br_loop_t'(next_rand() >> 24);
  endfunction

  // Upper LCG bits only since the low bits repeat quickly
  function automatic batch_pkg::pbs_nb_t rand_pbs();
    return batch_pkg::pbs_nb_t'((next_rand() >> 8) % batch_pkg::max_pbs_nb + 1);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("Error %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int err_start);
    $display("Test %s finished with %0d errors", name, err_cnt - err_start);
  endtask

  // ------------------------------
  // Host side
  // ------------------------------
  // Queue the samples of one batch and the results the multiply rule gives
  task automatic add_batch(input batch_pkg::br_loop_t loop, input batch_pkg::pbs_nb_t pbs);
    batch_pkg::sample_t smp;
    int i;
    for (i = 0; i < int'(pbs); i++) begin
      smp = batch_pkg::sample_t'(next_rand() >> 16);
      feed_q.push_back(smp);
      feed_first_q.push_back(i == 0);
      exp_q.push_back(batch_pkg::sample_t'(int'(smp) * int'(loop)));
      exp_last_q.push_back(i == int'(pbs) - 1);
    end
  endtask

  task automatic raise_req(input batch_pkg::br_loop_t loop, input batch_pkg::pbs_nb_t pbs);
    @(posedge clk);
    #1;
    host_cmd = {loop, pbs};
    host_req = 1'b1;
  endtask

  task automatic finish_handshake();
    do @(negedge clk); while (host_ack !== 1'b1);
    @(posedge clk);
    #1;
    host_req = 1'b0;
    do @(negedge clk); while (host_ack !== 1'b0);
  endtask

  task automatic send_batch(input batch_pkg::br_loop_t loop, input batch_pkg::pbs_nb_t pbs);
    raise_req(loop, pbs);
    #1;
    add_batch(loop, pbs);
    finish_handshake();
  endtask

  // Wait until every expected result came out and expect the DUT to be idle
  task automatic drain();
    do @(negedge clk); while (exp_q.size() != 0);
    @(negedge clk);
    if (feed_q.size() != 0) begin
      report_failure("samples left over after the last result");
    end
    if (all_idle !== 1'b1) begin
      report_mismatch("all_idle", 1, all_idle);
    end
  endtask

  // ------------------------------
  // Sample driver and observer
  // ------------------------------
  initial begin
    sample_vld = 1'b0;
    sample_in  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!feed_hold && feed_q.size() != 0) begin
        sample_vld = 1'b1;
        sample_in  = feed_q[0];
      end else begin
        sample_vld = 1'b0;
        sample_in  = '0;
      end
    end
  end

  // Outputs are stable at the falling edge and transfers happen at the next rising one
  always @(negedge clk) begin
    if (s_rst_n) begin
      if (in_flight == batch_pkg::batch_nb && sample_rdy && feed_q.size() != 0) begin
        if (feed_first_q[0]) begin
          report_failure("sample input opened for a new batch at the in-flight limit");
        end
      end
      first_acc = 1'b0;
      if (sample_vld && sample_rdy) begin
        if (feed_q.size() == 0) begin
          report_failure("sample accepted while none was offered");
        end else begin
          first_acc = feed_first_q.pop_front();
          void'(feed_q.pop_front());
        end
      end
      if (result_vld) begin
        beat_cnt++;
        if (exp_q.size() == 0) begin
          report_failure("result emitted with no result expected");
        end else begin
          exp_res  = exp_q.pop_front();
          exp_last = exp_last_q.pop_front();
          check_cnt++;
          if (result !== exp_res) begin
            report_mismatch("result", exp_res, result);
          end
          if (result_last !== exp_last) begin
            report_mismatch("result_last", exp_last, result_last);
          end
        end
      end else if (result_last) begin
        report_failure("result_last high without result_vld");
      end
      if (first_acc) begin
        in_flight++;
      end
      if (result_vld && result_last) begin
        in_flight--;
      end
      if (in_flight > batch_pkg::batch_nb) begin
        report_failure("more than batch_nb batches in flight");
      end
      if (in_flight > max_in_flight) begin
        max_in_flight = in_flight;
      end
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_idle_flag();
    int err_start;
    err_start = err_cnt;
    @(negedge clk);
    if (all_idle !== 1'b1) begin
      report_mismatch("all_idle", 1, all_idle);
    end
    if (host_ack !== 1'b0) begin
      report_mismatch("host_ack", 0, host_ack);
    end
    if (sample_rdy !== 1'b0) begin
      report_mismatch("sample_rdy", 0, sample_rdy);
    end
    send_batch(8'd5, 4'd3);
    if (all_idle !== 1'b0) begin
      report_mismatch("all_idle", 0, all_idle);
    end
    do begin
      @(negedge clk);
      if (all_idle !== 1'b0) begin
        report_mismatch("all_idle", 0, all_idle);
      end
    end while (result_last !== 1'b1);
    @(negedge clk);
    if (all_idle !== 1'b1) begin
      report_mismatch("all_idle", 1, all_idle);
    end
    drain();
    finish_test("idle flag", err_start);
  endtask

  task automatic test_single_batch();
    int err_start;
    int beats_start;
    err_start   = err_cnt;
    beats_start = beat_cnt;
    send_batch(8'd3, 4'd4);
    drain();
    if (beat_cnt - beats_start != 4) begin
      report_mismatch("result_vld beats", 4, beat_cnt - beats_start);
    end
    finish_test("single batch", err_start);
  endtask

  task automatic test_mixed_sizes();
    int err_start;
    int beats_start;
    err_start   = err_cnt;
    beats_start = beat_cnt;
    send_batch(8'd7, 4'd1);
    send_batch(8'd200, 4'd8);
    send_batch(8'd1, 4'd5);
    drain();
    if (beat_cnt - beats_start != 14) begin
      report_mismatch("result_vld beats", 14, beat_cnt - beats_start);
    end
    finish_test("mixed sizes", err_start);
  endtask

  task automatic test_in_flight_limit();
    int err_start;
    err_start     = err_cnt;
    max_in_flight = 0;
    repeat (4) send_batch(rand_loop(), 4'd8);
    drain();
    // Full batches overlap, so the limit must actually be reached
    if (max_in_flight != batch_pkg::batch_nb) begin
      report_mismatch("batches in flight", batch_pkg::batch_nb, max_in_flight);
    end
    if (in_flight != 0) begin
      report_mismatch("batches in flight", 0, in_flight);
    end
    finish_test("in-flight limit", err_start);
  endtask

  task automatic test_queue_backpressure();
    int err_start;
    int beats_start;
    int total;
    batch_pkg::br_loop_t loop;
    batch_pkg::pbs_nb_t  pbs;
    err_start   = err_cnt;
    beats_start = beat_cnt;
    total       = 0;
    feed_hold   = 1'b1;
    repeat (4) begin
      loop = rand_loop();
      pbs  = rand_pbs();
      total += int'(pbs);
      send_batch(loop, pbs);
    end
    // Two batches issued and two queued leave no room for the fifth
    loop = rand_loop();
    pbs  = rand_pbs();
    total += int'(pbs);
    raise_req(loop, pbs);
    #1;
    add_batch(loop, pbs);
    repeat (40) begin
      @(negedge clk);
      if (host_ack !== 1'b0) begin
        report_mismatch("host_ack", 0, host_ack);
      end
    end
    feed_hold = 1'b0;
    finish_handshake();
    drain();
    if (beat_cnt - beats_start != total) begin
      report_mismatch("result_vld beats", total, beat_cnt - beats_start);
    end
    finish_test("queue back-pressure", err_start);
  endtask

  task automatic test_random_run();
    int err_start;
    int beats_start;
    int total;
    batch_pkg::pbs_nb_t pbs;
    err_start   = err_cnt;
    beats_start = beat_cnt;
    total       = 0;
    repeat (40) begin
      pbs = rand_pbs();
      total += int'(pbs);
      send_batch(rand_loop(), pbs);
    end
    drain();
    if (beat_cnt - beats_start != total) begin
      report_mismatch("result_vld beats", total, beat_cnt - beats_start);
    end
    finish_test("random run", err_start);
  endtask

  // ------------------------------
  // Run control
  // ------------------------------
  initial begin
    host_cmd = '0;
    host_req = 1'b0;
    @(posedge s_rst_n);
    test_idle_flag();
    test_single_batch();
    test_mixed_sizes();
    test_in_flight_limit();
    test_queue_backpressure();
    test_random_run();
    $display("Summary: %0d results checked, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run stopped: tests did not finish within %0d cycles", timeout_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
/* Testbench clock and synchronous reset source, 8 ns clock period,
   reset held low for 16 cycles. */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic s_rst_n
);

  localparam int half_period = 4;
  localparam int rst_cycles  = 16;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Released just after an edge, like the other inputs
  initial begin
    s_rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #1;
    s_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/batch_top.sv ====
/* Top level of the batch scheduler. Connects the command queue, the batch
   tracker and the core model to the host, sample and result ports. */
`timescale 1ns/10ps
`default_nettype none

module batch_top (
  input  wire                   clk,
  input  wire                   s_rst_n,

  input  wire batch_pkg::batch_cmd_t host_cmd,
  input  wire                   host_req,
  output logic                  host_ack,

  input  wire batch_pkg::sample_t sample_in,
  input  wire                   sample_vld,
  output logic                  sample_rdy,

  output batch_pkg::sample_t    result,
  output logic                  result_vld,
  output logic                  result_last,

  output logic                  all_idle
);

  batch_pkg::batch_cmd_t q_cmd;
  logic                  q_vld;
  logic                  q_pop;
  batch_pkg::batch_cmd_t core_cmd;
  logic                  core_cmd_vld;
  logic                  send_data;
  logic                  in_last;
  logic                  out_last;

  cmd_queue u_cmd_queue (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .host_cmd     (host_cmd),
    .host_req     (host_req),
    .host_ack     (host_ack),
    .q_cmd        (q_cmd),
    .q_vld        (q_vld),
    .q_pop        (q_pop)
  );

  batch_tracker u_batch_tracker (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .q_cmd        (q_cmd),
    .q_vld        (q_vld),
    .q_pop        (q_pop),
    .core_cmd     (core_cmd),
    .core_cmd_vld (core_cmd_vld),
    .send_data    (send_data),
    .in_last      (in_last),
    .out_last     (out_last),
    .all_idle     (all_idle)
  );

  sample_core u_sample_core (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .core_cmd     (core_cmd),
    .core_cmd_vld (core_cmd_vld),
    .send_data    (send_data),
    .sample_in    (sample_in),
    .sample_vld   (sample_vld),
    .sample_rdy   (sample_rdy),
    .result       (result),
    .result_vld   (result_vld),
    .result_last  (result_last),
    .in_last      (in_last),
    .out_last     (out_last)
  );

endmodule

`default_nettype wire

// ==== logic/cmd_queue.sv ====
/* Host command intake. A four-phase req/ack handshake writes each command once
   into a batch_nb deep FIFO that the tracker pops. */
`timescale 1ns/10ps
`default_nettype none

module cmd_queue (
  input  wire                   clk,
  input  wire                   s_rst_n,

  input  wire batch_pkg::batch_cmd_t host_cmd,
  input  wire                   host_req,
  output logic                  host_ack,

  output batch_pkg::batch_cmd_t q_cmd,
  output logic                  q_vld,
  input  wire                   q_pop
);

  typedef enum logic {
    ack_st_idle,
    ack_st_hold
  } ack_st_e;

  ack_st_e                 ack_st;
  ack_st_e                 ack_st_nxt;

  batch_pkg::batch_cmd_t   fifo_mem [batch_pkg::batch_nb];
  batch_pkg::batch_ptr_t   wr_ptr;
  batch_pkg::batch_ptr_t   rd_ptr;
  batch_pkg::batch_cnt_t   fill_cnt;
  logic                    full;
  logic                    wr_en;

  assign full  = (fill_cnt == batch_pkg::batch_cnt_t'(batch_pkg::batch_nb));
  assign q_vld = (fill_cnt != '0);
  assign q_cmd = fifo_mem[rd_ptr];

  // ------------------------------
  // Handshake phase machine
  // ------------------------------
  // One write per request, taken on the idle phase only
  assign wr_en    = (ack_st == ack_st_idle) & host_req & ~full;
  assign host_ack = (ack_st == ack_st_hold);

  always_comb begin
    ack_st_nxt = ack_st;
    case (ack_st)
      ack_st_idle: begin
        if (host_req && !full) begin
          ack_st_nxt = ack_st_hold;
        end
      end
      ack_st_hold: begin
        // Host has seen the ack and released its request
        if (!host_req) begin
          ack_st_nxt = ack_st_idle;
        end
      end
      default: ack_st_nxt = ack_st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ack_st <= ack_st_idle;
    end else begin
      ack_st <= ack_st_nxt;
    end
  end

  // ------------------------------
  // Circular FIFO
  // ------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_mem[wr_ptr] <= host_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == batch_pkg::batch_ptr_t'(batch_pkg::batch_nb - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (rd_ptr == batch_pkg::batch_ptr_t'(batch_pkg::batch_nb - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, q_pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  // A full queue leaves the full state through a pop only, never gains a write
  assert property (@(posedge clk) disable iff (!s_rst_n)
    (full && !q_pop) |=> full)
    else $error("cmd_queue: command written while full");

endmodule

`default_nettype wire

// ==== logic/sample_core.sv ====
/* Transform core model. Multiplies each sample by its batch loop count and
   streams the results back per batch, in issue order, with a last flag. */
`timescale 1ns/10ps
`default_nettype none

module sample_core (
  input  wire                   clk,
  input  wire                   s_rst_n,

  input  wire batch_pkg::batch_cmd_t core_cmd,
  input  wire                   core_cmd_vld,
  input  wire                   send_data,

  input  wire batch_pkg::sample_t sample_in,
  input  wire                   sample_vld,
  output logic                  sample_rdy,

  output batch_pkg::sample_t    result,
  output logic                  result_vld,
  output logic                  result_last,

  output logic                  in_last,
  output logic                  out_last
);

  typedef logic [$clog2(batch_pkg::res_depth)-1:0]   res_ptr_t;
  typedef logic [$clog2(batch_pkg::res_depth+1)-1:0] res_cnt_t;

  // Issued commands waiting for their samples
  batch_pkg::batch_cmd_t desc_mem [batch_pkg::batch_nb];
  batch_pkg::batch_ptr_t desc_wr_ptr;
  batch_pkg::batch_ptr_t desc_rd_ptr;
  batch_pkg::batch_cmd_t head_cmd;
  batch_pkg::br_loop_t   head_loop;
  batch_pkg::pbs_nb_t    head_pbs;

  logic                  acc;
  batch_pkg::pbs_nb_t    in_cnt;
  logic [batch_pkg::sample_w+batch_pkg::loop_w-1:0] prod;

  // Results, each tagged with its batch sample count
  batch_pkg::sample_t    res_mem [batch_pkg::res_depth];
  batch_pkg::pbs_nb_t    pbs_mem [batch_pkg::res_depth];
  res_ptr_t              res_wr_ptr;
  res_ptr_t              res_rd_ptr;
  res_cnt_t              res_cnt;

  batch_pkg::batch_cnt_t fin_cnt;
  logic                  emitting;
  batch_pkg::pbs_nb_t    out_cnt;

  // ------------------------------
  // Input side
  // ------------------------------
  always_ff @(posedge clk) begin
    if (core_cmd_vld) begin
      desc_mem[desc_wr_ptr] <= core_cmd;
    end
  end

  assign head_cmd  = desc_mem[desc_rd_ptr];
  assign head_loop = head_cmd[batch_pkg::cmd_w-1 -: batch_pkg::loop_w];
  assign head_pbs  = head_cmd[batch_pkg::pbs_w-1:0];

  assign sample_rdy = send_data;
  assign acc        = sample_vld & send_data;
  assign in_last    = acc & (in_cnt == head_pbs - 1'b1);
  assign prod       = sample_in * head_loop;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      desc_wr_ptr <= '0;
      desc_rd_ptr <= '0;
      in_cnt      <= '0;
    end else begin
      if (core_cmd_vld) begin
        desc_wr_ptr <= (desc_wr_ptr == batch_pkg::batch_ptr_t'(batch_pkg::batch_nb - 1)) ?
                       '0 : desc_wr_ptr + 1'b1;
      end
      // Head descriptor retires with the last sample of its batch
      if (in_last) begin
        desc_rd_ptr <= (desc_rd_ptr == batch_pkg::batch_ptr_t'(batch_pkg::batch_nb - 1)) ?
                       '0 : desc_rd_ptr + 1'b1;
      end
      if (acc) begin
        in_cnt <= in_last ? '0 : in_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // Result buffer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (acc) begin
      res_mem[res_wr_ptr] <= prod[batch_pkg::sample_w-1:0];
      pbs_mem[res_wr_ptr] <= head_pbs;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      res_wr_ptr <= '0;
      res_rd_ptr <= '0;
      res_cnt    <= '0;
    end else begin
      if (acc) begin
        res_wr_ptr <= (res_wr_ptr == res_ptr_t'(batch_pkg::res_depth - 1)) ?
                      '0 : res_wr_ptr + 1'b1;
      end
      if (emitting) begin
        res_rd_ptr <= (res_rd_ptr == res_ptr_t'(batch_pkg::res_depth - 1)) ?
                      '0 : res_rd_ptr + 1'b1;
      end
      case ({acc, emitting})
        2'b10:   res_cnt <= res_cnt + 1'b1;
        2'b01:   res_cnt <= res_cnt - 1'b1;
        default: res_cnt <= res_cnt;
      endcase
    end
  end

  // ------------------------------
  // Output drain
  // ------------------------------
  // One idle cycle between batches keeps out_last after the tracker's receive step
  assign result_vld  = emitting;
  assign result      = res_mem[res_rd_ptr];
  assign out_last    = emitting & (out_cnt == pbs_mem[res_rd_ptr] - 1'b1);
  assign result_last = out_last;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      fin_cnt  <= '0;
      emitting <= 1'b0;
      out_cnt  <= '0;
    end else begin
      case ({in_last, out_last})
        2'b10:   fin_cnt <= fin_cnt + 1'b1;
        2'b01:   fin_cnt <= fin_cnt - 1'b1;
        default: fin_cnt <= fin_cnt;
      endcase
      if (!emitting && fin_cnt != '0) begin
        emitting <= 1'b1;
      end else if (out_last) begin
        emitting <= 1'b0;
      end
      if (emitting) begin
        out_cnt <= out_last ? '0 : out_cnt + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!s_rst_n)
    result_vld |-> (res_cnt != '0))
    else $error("sample_core: result emitted from an empty buffer");

endmodule

`default_nettype wire

// ==== tb.f ====
common/batch_pkg.sv
logic/cmd_queue.sv
batch_tracker/batch_tracker.sv
logic/sample_core.sv
logic/batch_top.sv
dv/tb_clk_gen.sv
dv/tb_batch_top.sv
